// ==== Bender.yml ====
package:
  name: calculator

sources:
  # Packages and interface first
  - common/calc_pkg.sv
  - common/calc_fsm_pkg.sv
  - common/calc_op_if.sv
  # Design
  - source/operand_entry.sv
  - calculator/add_sub_unit.sv
  - calculator/shift_add_multiplier.sv
  - calculator/calc_control.sv
  - source/calculator_top.sv
  # Testbench
  - target: simulation
    files:
      - verification/calculator_tb.sv

// ==== build.f ====
common/calc_pkg.sv
common/calc_fsm_pkg.sv
common/calc_op_if.sv
source/operand_entry.sv
calculator/add_sub_unit.sv
calculator/shift_add_multiplier.sv
calculator/calc_control.sv
source/calculator_top.sv
verification/calculator_tb.sv

// ==== calculator/add_sub_unit.sv ====
`timescale 1ns/10ps

module add_sub_unit (
    input logic          clk,
    input logic          nRST,
    calc_op_if.executor  bus
);

    calc_pkg::data_t sum_q;                 // Registered result

    // Result word, only meaningful alongside finish
    always_ff @(posedge clk) begin
        if (bus.start) begin
            if (bus.subtract) begin
                sum_q <= bus.operand_a - bus.operand_b;     // Wraps on borrow
            end else begin
                sum_q <= bus.operand_a + bus.operand_b;
            end
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            bus.finish <= 1'b0;
        end else begin
            bus.finish <= bus.start;        // Done one cycle after start
        end
    end

    assign bus.result = sum_q;

endmodule

// ==== calculator/calc_control.sv ====
`timescale 1ns/10ps

module calc_control (
    input  logic                      clk,
    input  logic                      nRST,
    input  calc_pkg::op_t             operator_input,
    input  logic                      equal_input,
    input  calc_pkg::data_t           operand_a,
    input  calc_pkg::data_t           operand_b,
    output calc_fsm_pkg::calc_state_t state,
    output logic                      clear_operands,
    calc_op_if.requester              alu_bus,
    calc_op_if.requester              mul_bus,
    output logic                      complete,
    output calc_pkg::data_t           display_output
);

    calc_fsm_pkg::calc_state_t next_state;
    calc_pkg::op_t             op_q;            // Latched operator
    logic                      op_valid;        // operator_input is one of the three codes
    logic                      is_mul;
    logic                      unit_done;
    calc_pkg::data_t           unit_result;

    assign op_valid = (operator_input == calc_pkg::op_add) ||
                      (operator_input == calc_pkg::op_sub) ||
                      (operator_input == calc_pkg::op_mul);

    assign is_mul = (op_q == calc_pkg::op_mul);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= calc_fsm_pkg::get_first;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            calc_fsm_pkg::get_first: begin
                if (op_valid) begin
                    next_state = calc_fsm_pkg::get_second;
                end
            end
            calc_fsm_pkg::get_second: begin
                if (equal_input) begin
                    next_state = calc_fsm_pkg::issue;
                end
            end
            calc_fsm_pkg::issue: begin
                next_state = calc_fsm_pkg::wait_unit;   // Start goes out this cycle
            end
            calc_fsm_pkg::wait_unit: begin
                if (unit_done) begin
                    next_state = calc_fsm_pkg::show_result;
                end
            end
            calc_fsm_pkg::show_result: begin
                next_state = calc_fsm_pkg::get_first;
            end
            default: begin
                next_state = calc_fsm_pkg::get_first;
            end
        endcase
    end

    // Operator only needs to be pressed, not held
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            op_q <= calc_pkg::op_add;
        end else if (state == calc_fsm_pkg::get_first && op_valid) begin
            op_q <= operator_input;
        end
    end

    // Both buses see the same operands, only one gets a start
    assign alu_bus.operand_a = operand_a;
    assign alu_bus.operand_b = operand_b;
    assign alu_bus.subtract  = (op_q == calc_pkg::op_sub);
    assign alu_bus.start     = (state == calc_fsm_pkg::issue) && !is_mul;

    assign mul_bus.operand_a = operand_a;
    assign mul_bus.operand_b = operand_b;
    assign mul_bus.subtract  = 1'b0;
    assign mul_bus.start     = (state == calc_fsm_pkg::issue) && is_mul;

    // Take the result from whichever unit reports done
    assign unit_done   = alu_bus.finish || mul_bus.finish;
    assign unit_result = alu_bus.finish ? alu_bus.result : mul_bus.result;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display_output <= '0;
        end else if (state == calc_fsm_pkg::wait_unit && unit_done) begin
            display_output <= unit_result;  // Visible with complete
        end
    end

    assign complete       = (state == calc_fsm_pkg::show_result);
    assign clear_operands = (state == calc_fsm_pkg::show_result);

    // A finish outside wait_unit would be lost
    assert_done_while_waiting : assert property (
        @(posedge clk) disable iff (!nRST)
        unit_done |-> (state == calc_fsm_pkg::wait_unit)
    );

    // Result mux favours the adder, so both at once is a fault
    assert_one_finish : assert property (
        @(posedge clk) disable iff (!nRST)
        !(alu_bus.finish && mul_bus.finish)
    );

endmodule

// ==== calculator/shift_add_multiplier.sv ====
`timescale 1ns/10ps

module shift_add_multiplier (
    input logic          clk,
    input logic          nRST,
    calc_op_if.executor  bus
);

    calc_pkg::data_t               mcand;       // Shifts left each step
    calc_pkg::data_t               mplier;      // Shifts right, bit 0 gates the add
    calc_pkg::data_t               acc;         // Low half of the product
    logic [calc_pkg::mul_cnt_w-1:0] step;
    logic                          busy;
    logic                          last_step;

    assign last_step = (step == calc_pkg::mul_cnt_w'(calc_pkg::mul_steps - 1));

    // Datapath, bits above 15 simply fall off
    always_ff @(posedge clk) begin
        if (bus.start) begin
            mcand  <= bus.operand_a;
            mplier <= bus.operand_b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy       <= 1'b0;
            step       <= '0;
            bus.finish <= 1'b0;
        end else begin
            bus.finish <= 1'b0;
            if (bus.start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy       <= 1'b0;
                    bus.finish <= 1'b1;     // acc holds the final sum next cycle
                end
            end
        end
    end

    assign bus.result = acc;

    // Controller must wait for finish before issuing again
    assert_no_start_busy : assert property (
        @(posedge clk) disable iff (!nRST)
        bus.start |-> !busy
    );

endmodule

// ==== common/calc_fsm_pkg.sv ====
package calc_fsm_pkg;

    // Controller sequencing states
    // Operand registers look at these to decide where a digit goes
    typedef enum logic [2:0] {
        get_first   = 3'b000,               // Building operand A
        get_second  = 3'b001,               // Building operand B
        issue       = 3'b010,               // Start pulse to the selected unit
        wait_unit   = 3'b011,               // Waiting for finish
        show_result = 3'b100                // Complete pulse, clear operands
    } calc_state_t;

endpackage

// ==== common/calc_op_if.sv ====
`timescale 1ns/10ps

// One operation request and its result between the controller and a unit
interface calc_op_if;

    calc_pkg::data_t operand_a;             // First operand
    calc_pkg::data_t operand_b;             // Second operand
    logic            subtract;              // Add/sub select, unused by multiplier
    logic            start;                 // One-cycle request pulse
    calc_pkg::data_t result;                // Valid while finish is high
    logic            finish;                // One-cycle done pulse

    modport requester (
        output operand_a,
        output operand_b,
        output subtract,
        output start,
        input  result,
        input  finish
    );

    modport executor (
        input  operand_a,
        input  operand_b,
        input  subtract,
        input  start,
        output result,
        output finish
    );

endinterface

// ==== common/calc_pkg.sv ====
package calc_pkg;

    // Datapath widths
    localparam int data_w  = 16;                // Operand and result width
    localparam int digit_w = 4;                 // One BCD keypad digit

    typedef logic [data_w-1:0]  data_t;
    typedef logic [digit_w-1:0] digit_t;

    // One-hot operator codes as they arrive from the keypad
    typedef logic [2:0] op_t;

    localparam op_t op_add = 3'b001;
    localparam op_t op_sub = 3'b010;
    localparam op_t op_mul = 3'b100;

    // Largest legal keypad digit
    localparam digit_t max_digit = 4'd9;

    // Multiplier iteration control
    localparam int mul_steps  = data_w;         // One step per multiplier bit
    localparam int mul_cnt_w  = $clog2(mul_steps);

endpackage

// ==== source/calculator_top.sv ====
`timescale 1ns/10ps

module calculator_top (
    input  logic             clk,
    input  logic             nRST,
    input  calc_pkg::digit_t digit,
    input  logic             read_input,
    input  calc_pkg::op_t    operator_input,
    input  logic             equal_input,
    output logic             complete,
    output calc_pkg::data_t  display_output
);

    calc_fsm_pkg::calc_state_t state;
    logic                      clear_operands;
    calc_pkg::data_t           operand_a;
    calc_pkg::data_t           operand_b;

    calc_op_if alu_bus ();
    calc_op_if mul_bus ();

    calc_control u_control (
        .clk            (clk),
        .nRST           (nRST),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .state          (state),
        .clear_operands (clear_operands),
        .alu_bus        (alu_bus.requester),
        .mul_bus        (mul_bus.requester),
        .complete       (complete),
        .display_output (display_output)
    );

    operand_entry u_operands (
        .clk            (clk),
        .nRST           (nRST),
        .state          (state),
        .digit          (digit),
        .read_input     (read_input),
        .clear_operands (clear_operands),
        .operand_a      (operand_a),
        .operand_b      (operand_b)
    );

    add_sub_unit u_alu (
        .clk  (clk),
        .nRST (nRST),
        .bus  (alu_bus.executor)
    );

    shift_add_multiplier u_mul (
        .clk  (clk),
        .nRST (nRST),
        .bus  (mul_bus.executor)
    );

endmodule

// ==== source/operand_entry.sv ====
`timescale 1ns/10ps

module operand_entry (
    input  logic                      clk,
    input  logic                      nRST,
    input  calc_fsm_pkg::calc_state_t state,
    input  calc_pkg::digit_t          digit,
    input  logic                      read_input,
    input  logic                      clear_operands,
    output calc_pkg::data_t           operand_a,
    output calc_pkg::data_t           operand_b
);

    // value * 10 + digit, wrapping at 2^16
    function automatic calc_pkg::data_t accumulate(
        input calc_pkg::data_t  value,
        input calc_pkg::digit_t d
    );
        calc_pkg::data_t times_ten;
        times_ten = (value << 3) + (value << 1);    // 8x + 2x
        return times_ten + calc_pkg::data_t'(d);
    endfunction

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand_a <= '0;
            operand_b <= '0;
        end else if (clear_operands) begin
            operand_a <= '0;                        // Fresh start after a result
            operand_b <= '0;
        end else if (read_input) begin
            case (state)
                calc_fsm_pkg::get_first: begin
                    operand_a <= accumulate(operand_a, digit);
                end
                calc_fsm_pkg::get_second: begin
                    operand_b <= accumulate(operand_b, digit);
                end
                default: begin
                    // Busy, key dropped
                end
            endcase
        end
    end

    // Keypad only ever sends decimal digits
    assert_digit_range : assert property (
        @(posedge clk) disable iff (!nRST)
        read_input |-> (digit <= calc_pkg::max_digit)
    );

endmodule

// ==== verification/calculator_tb.sv ====
`timescale 1ns/10ps

module calculator_tb;

    localparam int timeout_cycles = 100;        // Per wait loop
    localparam int random_runs    = 20;

    logic             clk;
    logic             nRST;
    calc_pkg::digit_t digit;
    logic             read_input;
    calc_pkg::op_t    operator_input;
    logic             equal_input;
    logic             complete;
    calc_pkg::data_t  display_output;

    integer seed = 32'hb240_ee8a;

    calculator_top UUT (
        .clk            (clk),
        .nRST           (nRST),
        .digit          (digit),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period
    end

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input calc_pkg::data_t expected,
                              input calc_pkg::data_t actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t ns %s expected %0d (0x%04h) actual %0d (0x%04h)",
                     $time, name, expected, expected, actual, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t ns %s expected %b actual %b",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Lands 10 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // Calculator rules, result kept to 16 bits
    function automatic calc_pkg::data_t expected_result(input calc_pkg::data_t a,
                                                        input calc_pkg::data_t b,
                                                        input calc_pkg::op_t op);
        logic [31:0] product;
        product = {16'b0, a} * {16'b0, b};
        case (op)
            calc_pkg::op_add: return a + b;
            calc_pkg::op_sub: return a - b;
            default:          return product[15:0];
        endcase
    endfunction

    function automatic int unsigned random_below(input int unsigned limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    task automatic press_digit(input int unsigned d);
        digit      = calc_pkg::digit_t'(d);
        read_input = 1'b1;
        next_cycle();
        read_input = 1'b0;
    endtask

    task automatic press_operator(input calc_pkg::op_t op);
        operator_input = op;
        next_cycle();
        operator_input = '0;                    // Latched, no need to hold
    endtask

    task automatic press_equal();
        equal_input = 1'b1;
        next_cycle();
        equal_input = 1'b0;
    endtask

    // Most significant digit first
    task automatic enter_number(input int unsigned value);
        int          digs[10];
        int          n;
        int unsigned rest;
        n    = 0;
        rest = value;
        do begin
            digs[n] = rest % 10;
            n++;
            rest = rest / 10;
        end while (rest != 0);
        for (int i = n - 1; i >= 0; i--) begin
            press_digit(digs[i]);
        end
    endtask

    task automatic wait_complete(output calc_pkg::data_t value);
        int cycles;
        cycles = 0;
        while (complete !== 1'b1) begin
            if (cycles >= timeout_cycles) begin
                $display("Timed out after %0d cycles waiting for complete", timeout_cycles);
                stop_with_failure();
            end else begin
                next_cycle();
                cycles++;
            end
        end
        value = display_output;
        next_cycle();
        check_bit("complete", 1'b0, complete);  // One pulse only
        check_data("operand_a", '0, UUT.operand_a);
        check_data("operand_b", '0, UUT.operand_b);
    endtask

    task automatic compute(input int unsigned a, input int unsigned b,
                           input calc_pkg::op_t op, output calc_pkg::data_t value);
        enter_number(a);
        press_operator(op);
        enter_number(b);
        press_equal();
        wait_complete(value);
    endtask

    // Entered value is the decimal number modulo 2^16
    task automatic check_calc(input int unsigned a, input int unsigned b,
                              input calc_pkg::op_t op);
        calc_pkg::data_t got;
        compute(a, b, op, got);
        check_data("display_output",
                   expected_result(calc_pkg::data_t'(a), calc_pkg::data_t'(b), op), got);
    endtask

    task automatic test_reset();
        check_bit("complete", 1'b0, complete);
        check_data("display_output", '0, display_output);
        repeat (10) begin
            next_cycle();
            check_bit("complete", 1'b0, complete);  // Idle, nothing pending
        end
    endtask

    task automatic test_add();
        check_calc(123, 4567, calc_pkg::op_add);
        check_calc(60000, 9000, calc_pkg::op_add);
        check_calc(0, 0, calc_pkg::op_add);
    endtask

    task automatic test_sub();
        check_calc(5, 12, calc_pkg::op_sub);    // Wraps below zero
        check_calc(4567, 123, calc_pkg::op_sub);
        check_calc(0, 1, calc_pkg::op_sub);
    endtask

    task automatic test_mul();
        check_calc(300, 300, calc_pkg::op_mul);
        check_calc(12, 34, calc_pkg::op_mul);
        check_calc(99999, 7, calc_pkg::op_mul); // Operand itself wraps
        check_calc(65535, 0, calc_pkg::op_mul);
    endtask

    task automatic test_ignored_inputs();
        calc_pkg::data_t got;
        press_digit(4);
        press_digit(2);
        press_operator(3'b011);                 // Not one-hot
        press_equal();                          // Still in get_first
        press_digit(7);                         // A becomes 427
        press_operator(calc_pkg::op_mul);
        enter_number(25);
        press_equal();
        press_digit(9);                         // Multiplier busy
        press_digit(3);
        check_data("operand_a", 16'd427, UUT.operand_a);    // Busy keys dropped
        check_data("operand_b", 16'd25, UUT.operand_b);
        wait_complete(got);
        check_data("display_output", expected_result(16'd427, 16'd25, calc_pkg::op_mul), got);

        enter_number(81);
        press_operator(calc_pkg::op_sub);
        enter_number(6);
        press_equal();
        press_digit(5);                         // Adder busy
        check_data("operand_a", 16'd81, UUT.operand_a);
        check_data("operand_b", 16'd6, UUT.operand_b);
        wait_complete(got);
        check_data("display_output", expected_result(16'd81, 16'd6, calc_pkg::op_sub), got);
    endtask

    task automatic test_random();
        int unsigned   a;
        int unsigned   b;
        int unsigned   limit;
        calc_pkg::op_t op;
        repeat (random_runs) begin
            limit = 1;
            repeat (1 + random_below(5)) limit = limit * 10;
            a     = random_below(limit);
            limit = 1;
            repeat (1 + random_below(5)) limit = limit * 10;
            b     = random_below(limit);
            case (random_below(3))
                0:       op = calc_pkg::op_add;
                1:       op = calc_pkg::op_sub;
                default: op = calc_pkg::op_mul;
            endcase
            check_calc(a, b, op);               // Back to back, operands cleared
        end
    endtask

    initial begin
        nRST           = 1'b0;
        digit          = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        nRST = 1'b1;

        test_reset();
        test_add();
        test_sub();
        test_mul();
        test_ignored_inputs();
        test_random();

        $display("Test OK");
        $finish;
    end

endmodule
